//--- src/dcache_pkg.sv
package dcache_pkg;

    // Address and data word sizes
    localparam int ADDR_WIDTH = 32;
    localparam int WORD_WIDTH = 32;
    localparam int BYTES_PER_WORD = WORD_WIDTH / 8;

    // Four hardware threads share the cache
    localparam int THREAD_IDX_WIDTH = 2;

    // Upper address bits that select the uncached I/O region
    localparam int IO_PREFIX_WIDTH = 16;
    localparam logic [IO_PREFIX_WIDTH-1:0] IO_ADDR_PREFIX = 16'hffff;

    typedef logic [WORD_WIDTH-1:0] scalar_t;

    typedef logic [THREAD_IDX_WIDTH-1:0] thread_idx_t;

    // Access size of a load or store
    typedef enum logic [1:0]
    {
        MEM_B     = 2'd0,   // Byte
        MEM_S     = 2'd1,   // 16-bit
        MEM_L     = 2'd2,   // 32-bit
        MEM_BLOCK = 2'd3    // Whole line vector
    } mem_op_t;

endpackage

//--- src/mem_access_decode.sv
`timescale 1ns/1ps

module mem_access_decode
    import dcache_pkg::*;
#(
    parameter int LINE_WORDS = 16
)(
    input  logic    request_valid,
    input  mem_op_t request_op,
    input  logic    request_is_load,
    input  scalar_t request_addr,
    input  logic    store_mask_nonzero,
    output logic    cached_load,
    output logic    cached_store,
    output logic    io_read,
    output logic    io_write,
    output logic    is_io,
    output logic    unaligned
);

    localparam int OFFSET_WIDTH = $clog2(LINE_WORDS * BYTES_PER_WORD);

    logic cached_access;
    logic io_access;

    // Top 64 KiB of the address space goes to the I/O port
    assign is_io = request_addr[ADDR_WIDTH-1 -: IO_PREFIX_WIDTH] == IO_ADDR_PREFIX;

    assign cached_access = request_valid && !is_io;
    assign io_access = request_valid && is_io;

    // Alignment depends on the access size
    always_comb
    begin
        case (request_op)
            MEM_S:
                unaligned = request_addr[0];
            MEM_L:
                unaligned = |request_addr[1:0];
            MEM_BLOCK:
                unaligned = |request_addr[OFFSET_WIDTH-1:0];
            default:
                unaligned = 1'b0;
        endcase
    end

    assign cached_load = cached_access && request_is_load;

    // Nothing to write if every byte is masked off
    assign cached_store = cached_access
        && !request_is_load
        && !unaligned
        && store_mask_nonzero;

    // I/O accesses are passed through regardless of alignment
    assign io_read = io_access && request_is_load;
    assign io_write = io_access && !request_is_load;

endmodule

//--- src/way_hit_check.sv
`timescale 1ns/1ps

module way_hit_check
    import dcache_pkg::*;
#(
    parameter int NUM_WAYS = 4,
    parameter int NUM_SETS = 64,
    parameter int LINE_WORDS = 16,
    localparam int OFFSET_WIDTH = $clog2(LINE_WORDS * BYTES_PER_WORD),
    localparam int SET_WIDTH = $clog2(NUM_SETS),
    localparam int TAG_WIDTH = ADDR_WIDTH - SET_WIDTH - OFFSET_WIDTH,
    localparam int WAY_IDX_WIDTH = $clog2(NUM_WAYS)
)(
    input  scalar_t                             request_addr,
    input  logic [NUM_WAYS-1:0]                 way_valid,
    input  logic [NUM_WAYS-1:0][TAG_WIDTH-1:0]  way_tag,
    output logic                                hit,
    output logic [WAY_IDX_WIDTH-1:0]            hit_way
);

    logic [TAG_WIDTH-1:0] request_tag;
    logic [NUM_WAYS-1:0]  way_match;

    assign request_tag = request_addr[ADDR_WIDTH-1 -: TAG_WIDTH];

    for (genvar w = 0; w < NUM_WAYS; w++)
    begin : g_match
        assign way_match[w] = way_valid[w] && way_tag[w] == request_tag;
    end

    assign hit = |way_match;

    // A line lives in at most one way, so OR-ing the indices is enough
    always_comb
    begin
        hit_way = '0;
        for (int w = 0; w < NUM_WAYS; w++)
        begin
            if (way_match[w])
                hit_way = hit_way | WAY_IDX_WIDTH'(w);
        end
    end

endmodule

//--- src/store_align.sv
`timescale 1ns/1ps

module store_align
    import dcache_pkg::*;
#(
    parameter int LINE_WORDS = 16,
    localparam int LINE_BYTES = LINE_WORDS * BYTES_PER_WORD,
    localparam int LINE_BITS = LINE_WORDS * WORD_WIDTH
)(
    input  mem_op_t                         request_op,
    input  scalar_t                         request_addr,
    input  scalar_t [LINE_WORDS-1:0]        store_value,
    input  logic [LINE_WORDS-1:0]           lane_mask,
    output logic [LINE_BYTES-1:0]           store_mask,
    output logic [LINE_BITS-1:0]            store_data,
    output logic                            store_mask_nonzero
);

    localparam int OFFSET_WIDTH = $clog2(LINE_BYTES);
    localparam int BYTE_IDX_WIDTH = $clog2(BYTES_PER_WORD);

    logic [OFFSET_WIDTH-BYTE_IDX_WIDTH-1:0] word_idx;
    logic [LINE_WORDS-1:0]     addr_word_mask;
    logic [LINE_WORDS-1:0]     word_mask;
    logic [BYTES_PER_WORD-1:0] byte_mask;
    logic [LINE_BITS-1:0]      block_data;
    scalar_t                   swapped_value;

    function automatic scalar_t byte_swap(input scalar_t value);
        return {value[7:0], value[15:8], value[23:16], value[31:24]};
    endfunction

    // Word 0 of the line sits in the top slot
    assign word_idx = request_addr[OFFSET_WIDTH-1:BYTE_IDX_WIDTH];
    assign addr_word_mask = {1'b1, {(LINE_WORDS - 1){1'b0}}} >> word_idx;

    assign swapped_value = byte_swap(store_value[0]);

    for (genvar i = 0; i < LINE_WORDS; i++)
    begin : g_block_swap
        assign block_data[i * WORD_WIDTH +: WORD_WIDTH] = byte_swap(store_value[i]);
    end

    always_comb
    begin
        word_mask = addr_word_mask;
        byte_mask = 4'b1111;
        store_data = {LINE_WORDS{swapped_value}};
        case (request_op)
            MEM_B:
            begin
                // Lowest address byte maps to the top mask bit
                byte_mask = 4'b1000 >> request_addr[1:0];
                store_data = {LINE_BYTES{store_value[0][7:0]}};
            end
            MEM_S:
            begin
                byte_mask = request_addr[1] ? 4'b0011 : 4'b1100;
                store_data = {(LINE_WORDS * 2){swapped_value[31:16]}};
            end
            MEM_L:
                store_data = {LINE_WORDS{swapped_value}};
            MEM_BLOCK:
            begin
                word_mask = lane_mask;
                store_data = block_data;
            end
            default:
                word_mask = '0;
        endcase
    end

    // Expand the slot and byte masks into one bit per line byte
    for (genvar b = 0; b < LINE_BYTES; b++)
    begin : g_mask
        assign store_mask[b] = word_mask[b / BYTES_PER_WORD]
            & byte_mask[b % BYTES_PER_WORD];
    end

    assign store_mask_nonzero = |store_mask;

endmodule

//--- src/line_data_ram.sv
`timescale 1ns/1ps

module line_data_ram
    import dcache_pkg::*;
#(
    parameter int NUM_WAYS = 4,
    parameter int NUM_SETS = 64,
    parameter int LINE_WORDS = 16,
    localparam int WAY_IDX_WIDTH = $clog2(NUM_WAYS),
    localparam int SET_WIDTH = $clog2(NUM_SETS),
    localparam int LINE_BITS = LINE_WORDS * WORD_WIDTH
)(
    input  logic                        clk,
    input  logic                        read_en,
    input  logic [WAY_IDX_WIDTH-1:0]    read_way,
    input  logic [SET_WIDTH-1:0]        read_set,
    input  logic                        write_en,
    input  logic [WAY_IDX_WIDTH-1:0]    write_way,
    input  logic [SET_WIDTH-1:0]        write_set,
    input  logic [LINE_BITS-1:0]        write_data,
    output logic [LINE_BITS-1:0]        read_data
);

    logic [LINE_BITS-1:0] mem [NUM_WAYS * NUM_SETS];

    always_ff @(posedge clk)
    begin
        if (write_en)
            mem[{write_way, write_set}] <= write_data;

        // Same-address collision forwards the fill data
        if (read_en)
        begin
            if (write_en && write_way == read_way && write_set == read_set)
                read_data <= write_data;
            else
                read_data <= mem[{read_way, read_set}];
        end
    end

endmodule

//--- src/stage_result.sv
`timescale 1ns/1ps

module stage_result
    import dcache_pkg::*;
(
    input  logic        clk,
    input  logic        reset,
    input  logic        request_valid,
    input  thread_idx_t request_thread,
    input  mem_op_t     request_op,
    input  logic        request_is_load,
    input  logic        cached_load,
    input  logic        hit,
    input  logic        unaligned,
    input  logic        is_io,
    output logic        result_valid,
    output thread_idx_t result_thread,
    output mem_op_t     result_op,
    output logic        suspend_thread,
    output logic        fault,
    output logic        fault_is_store,
    output logic        result_is_io
);

    always_ff @(posedge clk, posedge reset)
    begin
        if (reset)
        begin
            result_valid <= 1'b0;
            suspend_thread <= 1'b0;
            fault <= 1'b0;
        end
        else
        begin
            result_valid <= request_valid;

            // Thread waits for the L2 fill on a clean miss
            suspend_thread <= cached_load && !hit && !unaligned;

            // Alignment is only enforced on cached accesses
            fault <= request_valid && !is_io && unaligned;
        end
    end

    always_ff @(posedge clk)
    begin
        result_thread <= request_thread;
        result_op <= request_op;
        fault_is_store <= !request_is_load;
        result_is_io <= is_io;
    end

endmodule

//--- src/dcache_data_stage.sv
`timescale 1ns/1ps

module dcache_data_stage
    import dcache_pkg::*;
#(
    parameter int NUM_WAYS = 4,
    parameter int NUM_SETS = 64,
    parameter int LINE_WORDS = 16,
    localparam int LINE_BYTES = LINE_WORDS * BYTES_PER_WORD,
    localparam int LINE_BITS = LINE_WORDS * WORD_WIDTH,
    localparam int OFFSET_WIDTH = $clog2(LINE_BYTES),
    localparam int SET_WIDTH = $clog2(NUM_SETS),
    localparam int WAY_IDX_WIDTH = $clog2(NUM_WAYS),
    localparam int TAG_WIDTH = ADDR_WIDTH - SET_WIDTH - OFFSET_WIDTH,
    localparam int LINE_ADDR_WIDTH = ADDR_WIDTH - OFFSET_WIDTH
)(
    input  logic                                clk,
    input  logic                                reset,

    // Request from the tag stage
    input  logic                                request_valid,
    input  mem_op_t                             request_op,
    input  logic                                request_is_load,
    input  thread_idx_t                         request_thread,
    input  scalar_t                             request_addr,
    input  scalar_t [LINE_WORDS-1:0]            store_value,
    input  logic [LINE_WORDS-1:0]               lane_mask,
    input  logic [NUM_WAYS-1:0]                 way_valid,
    input  logic [NUM_WAYS-1:0][TAG_WIDTH-1:0]  way_tag,

    // Line fill from L2
    input  logic                                fill_en,
    input  logic [WAY_IDX_WIDTH-1:0]            fill_way,
    input  logic [SET_WIDTH-1:0]                fill_set,
    input  logic [LINE_BITS-1:0]                fill_data,

    // Load miss to L2
    output logic                                cache_miss,
    output logic [LINE_ADDR_WIDTH-1:0]          miss_line_addr,
    output thread_idx_t                         miss_thread,

    // Store path
    output logic                                store_en,
    output logic [LINE_BYTES-1:0]               store_mask,
    output logic [LINE_ADDR_WIDTH-1:0]          store_line_addr,
    output logic [LINE_BITS-1:0]                store_data,
    output thread_idx_t                         store_thread,

    // Uncached I/O
    output logic                                io_read_en,
    output logic                                io_write_en,
    output scalar_t                             io_addr,
    output scalar_t                             io_write_value,
    output thread_idx_t                         io_thread,

    // To writeback
    output logic                                result_valid,
    output thread_idx_t                         result_thread,
    output mem_op_t                             result_op,
    output logic [LINE_BITS-1:0]                load_data,
    output logic                                suspend_thread,
    output logic                                fault,
    output logic                                fault_is_store,
    output logic                                result_is_io
);

    logic cached_load;
    logic cached_store;
    logic io_read;
    logic io_write;
    logic is_io;
    logic unaligned;
    logic store_mask_nonzero;
    logic hit;
    logic [WAY_IDX_WIDTH-1:0]   hit_way;
    logic                       read_en;
    logic [SET_WIDTH-1:0]       read_set;
    logic [LINE_ADDR_WIDTH-1:0] line_addr;

    mem_access_decode #(
        .LINE_WORDS(LINE_WORDS)
    ) i_decode (
        .request_valid(request_valid),
        .request_op(request_op),
        .request_is_load(request_is_load),
        .request_addr(request_addr),
        .store_mask_nonzero(store_mask_nonzero),
        .cached_load(cached_load),
        .cached_store(cached_store),
        .io_read(io_read),
        .io_write(io_write),
        .is_io(is_io),
        .unaligned(unaligned)
    );

    way_hit_check #(
        .NUM_WAYS(NUM_WAYS),
        .NUM_SETS(NUM_SETS),
        .LINE_WORDS(LINE_WORDS)
    ) i_hit_check (
        .request_addr(request_addr),
        .way_valid(way_valid),
        .way_tag(way_tag),
        .hit(hit),
        .hit_way(hit_way)
    );

    store_align #(
        .LINE_WORDS(LINE_WORDS)
    ) i_store_align (
        .request_op(request_op),
        .request_addr(request_addr),
        .store_value(store_value),
        .lane_mask(lane_mask),
        .store_mask(store_mask),
        .store_data(store_data),
        .store_mask_nonzero(store_mask_nonzero)
    );

    // Only a hitting load reads the data array
    assign read_en = cached_load && hit;
    assign read_set = request_addr[OFFSET_WIDTH +: SET_WIDTH];
    assign line_addr = request_addr[ADDR_WIDTH-1:OFFSET_WIDTH];

    line_data_ram #(
        .NUM_WAYS(NUM_WAYS),
        .NUM_SETS(NUM_SETS),
        .LINE_WORDS(LINE_WORDS)
    ) i_data_ram (
        .clk(clk),
        .read_en(read_en),
        .read_way(hit_way),
        .read_set(read_set),
        .write_en(fill_en),
        .write_way(fill_way),
        .write_set(fill_set),
        .write_data(fill_data),
        .read_data(load_data)
    );

    // A misaligned load faults instead of going to L2
    assign cache_miss = cached_load && !hit && !unaligned;
    assign miss_line_addr = line_addr;
    assign miss_thread = request_thread;

    assign store_en = cached_store;
    assign store_line_addr = line_addr;
    assign store_thread = request_thread;

    assign io_read_en = io_read;
    assign io_write_en = io_write;
    assign io_addr = {16'd0, request_addr[15:0]};
    assign io_write_value = store_value[0];
    assign io_thread = request_thread;

    stage_result i_result (
        .clk(clk),
        .reset(reset),
        .request_valid(request_valid),
        .request_thread(request_thread),
        .request_op(request_op),
        .request_is_load(request_is_load),
        .cached_load(cached_load),
        .hit(hit),
        .unaligned(unaligned),
        .is_io(is_io),
        .result_valid(result_valid),
        .result_thread(result_thread),
        .result_op(result_op),
        .suspend_thread(suspend_thread),
        .fault(fault),
        .fault_is_store(fault_is_store),
        .result_is_io(result_is_io)
    );

endmodule

//--- dv/tb_dcache_data_stage.sv
`timescale 1ns/1ps

module tb_dcache_data_stage
    import dcache_pkg::*;
();

    localparam int NUM_WAYS = 4;
    localparam int NUM_SETS = 64;
    localparam int LINE_WORDS = 16;
    localparam int LINE_BITS = LINE_WORDS * WORD_WIDTH;
    localparam int LINE_BYTES = LINE_WORDS * BYTES_PER_WORD;
    localparam int TAG_WIDTH = 20;
    localparam int N_FILL = 24;
    localparam int N_HIT = 32;
    localparam int N_COLLIDE = 4;
    localparam int N_MISS = 16;
    localparam int N_SCALAR = 24;
    localparam int N_BLOCK = 12;
    localparam int N_UNALIGNED = 16;
    localparam int N_IO = 12;
    localparam int NUM_TESTS = N_FILL + N_HIT + N_COLLIDE + N_MISS + N_SCALAR + N_BLOCK + 1
        + N_UNALIGNED + N_IO;

    logic clk;
    logic reset;
    logic request_valid;
    mem_op_t request_op;
    logic request_is_load;
    thread_idx_t request_thread;
    scalar_t request_addr;
    scalar_t [LINE_WORDS-1:0] store_value;
    logic [LINE_WORDS-1:0] lane_mask;
    logic [NUM_WAYS-1:0] way_valid;
    logic [NUM_WAYS-1:0][TAG_WIDTH-1:0] way_tag;
    logic fill_en;
    logic [1:0] fill_way;
    logic [5:0] fill_set;
    logic [LINE_BITS-1:0] fill_data;
    logic cache_miss;
    logic [25:0] miss_line_addr;
    thread_idx_t miss_thread;
    logic store_en;
    logic [LINE_BYTES-1:0] store_mask;
    logic [25:0] store_line_addr;
    logic [LINE_BITS-1:0] store_data;
    thread_idx_t store_thread;
    logic io_read_en;
    logic io_write_en;
    scalar_t io_addr;
    scalar_t io_write_value;
    thread_idx_t io_thread;
    logic result_valid;
    thread_idx_t result_thread;
    mem_op_t result_op;
    logic [LINE_BITS-1:0] load_data;
    logic suspend_thread;
    logic fault;
    logic fault_is_store;
    logic result_is_io;

    integer seed;

    // Testbench copy of the tag array and of the line contents
    logic model_valid [NUM_WAYS][NUM_SETS];
    logic [TAG_WIDTH-1:0] model_tag [NUM_WAYS][NUM_SETS];
    logic [LINE_BITS-1:0] shadow [NUM_WAYS * NUM_SETS];
    int fill_way_q[$];
    int fill_set_q[$];

    // Expected values for the request in flight
    logic exp_io;
    logic exp_unaligned;
    logic exp_hit;
    int exp_way;
    logic [LINE_BYTES-1:0] exp_mask;
    logic [LINE_BITS-1:0] exp_data;

    // Expectations carried to the result cycle
    logic prev_valid;
    logic prev_suspend;
    logic prev_fault;
    logic prev_read;
    logic prev_store;
    logic prev_io;
    thread_idx_t prev_thread;
    mem_op_t prev_op;
    logic [LINE_BITS-1:0] prev_line;

    dcache_data_stage i_dut (.*);

    always #4 clk = ~clk;

    task automatic check_value(input string name, input logic [LINE_BITS-1:0] expected,
                               input logic [LINE_BITS-1:0] actual);
        if (actual !== expected)
        begin
            $display("[ERROR] %0t ns %s: expected %0h, actual %0h",
                $time, name, expected, actual);
            $display("SIMULATION FAILED");
            $fatal(1, "Value mismatch on %s", name);
        end
    endtask

    // Expected decode, hit and store image from the access rules
    function automatic void predict();
        int size;
        int slot;
        int bo;
        int pos;
        logic [5:0] set_idx;
        set_idx = request_addr[11:6];
        exp_io = request_addr[31:16] == 16'hffff;
        case (request_op)
            MEM_B: size = 1;
            MEM_S: size = 2;
            default: size = 4;
        endcase
        case (request_op)
            MEM_S: exp_unaligned = request_addr[0];
            MEM_L: exp_unaligned = request_addr[1:0] != 2'd0;
            MEM_BLOCK: exp_unaligned = request_addr[5:0] != 6'd0;
            default: exp_unaligned = 1'b0;
        endcase
        exp_hit = 1'b0;
        exp_way = 0;
        for (int w = 0; w < NUM_WAYS; w++)
        begin
            if (model_valid[w][set_idx] && model_tag[w][set_idx] == request_addr[31:12])
            begin
                exp_hit = 1'b1;
                exp_way = w;
            end
        end
        slot = LINE_WORDS - 1 - request_addr[5:2];
        bo = request_addr[1:0];
        for (int j = 0; j < LINE_BYTES; j++)
        begin
            pos = j % 4;
            if (request_op == MEM_BLOCK)
            begin
                exp_mask[j] = lane_mask[j / 4];
                exp_data[j * 8 +: 8] = store_value[j / 4][(3 - pos) * 8 +: 8];
            end
            else
            begin
                // Lowest address byte is the top byte of its slot
                exp_mask[j] = j / 4 == slot && 3 - pos >= bo && 3 - pos < bo + size;
                exp_data[j * 8 +: 8] = store_value[0][(size - 1 - pos % size) * 8 +: 8];
            end
        end
    endfunction

    function automatic scalar_t make_addr(input logic [TAG_WIDTH-1:0] tag,
                                          input logic [5:0] set_idx, input mem_op_t op,
                                          input logic [5:0] raw);
        logic [5:0] offset;
        case (op)
            MEM_S: offset = raw & 6'h3e;
            MEM_L: offset = raw & 6'h3c;
            MEM_BLOCK: offset = 6'd0;
            default: offset = raw;
        endcase
        return {tag, set_idx, offset};
    endfunction

    task automatic fill_line(input int way, input int set_idx);
        logic [LINE_BITS-1:0] line;
        logic [TAG_WIDTH-1:0] tag;
        for (int i = 0; i < LINE_WORDS; i++)
            line[i * WORD_WIDTH +: WORD_WIDTH] = $random(seed);
        // Way number in the low tag bits keeps tags within a set distinct
        tag = {1'b0, 17'($random(seed)), 2'(way)};
        @(posedge clk);
        request_valid <= 1'b0;
        fill_en <= 1'b1;
        fill_way <= 2'(way);
        fill_set <= 6'(set_idx);
        fill_data <= line;
        shadow[way * NUM_SETS + set_idx] = line;
        model_tag[way][set_idx] = tag;
        model_valid[way][set_idx] = 1'b1;
        fill_way_q.push_back(way);
        fill_set_q.push_back(set_idx);
    endtask

    task automatic drive_request(input mem_op_t op, input logic is_load, input scalar_t addr,
                                 input logic [LINE_WORDS-1:0] lanes);
        scalar_t [LINE_WORDS-1:0] values;
        logic [NUM_WAYS-1:0] valid_v;
        logic [NUM_WAYS-1:0][TAG_WIDTH-1:0] tag_v;
        for (int i = 0; i < LINE_WORDS; i++)
            values[i] = $random(seed);
        for (int w = 0; w < NUM_WAYS; w++)
        begin
            valid_v[w] = model_valid[w][addr[11:6]];
            tag_v[w] = model_tag[w][addr[11:6]];
        end
        @(posedge clk);
        fill_en <= 1'b0;
        request_valid <= 1'b1;
        request_op <= op;
        request_is_load <= is_load;
        request_thread <= 2'($random(seed));
        request_addr <= addr;
        store_value <= values;
        lane_mask <= lanes;
        way_valid <= valid_v;
        way_tag <= tag_v;
    endtask

    // Load and refill of the same line in one cycle, the load sees the new line
    task automatic load_during_fill(input int way, input int set_idx);
        logic [LINE_BITS-1:0] line;
        for (int i = 0; i < LINE_WORDS; i++)
            line[i * WORD_WIDTH +: WORD_WIDTH] = $random(seed);
        drive_request(MEM_L, 1'b1, make_addr(model_tag[way][set_idx], 6'(set_idx),
            MEM_L, 6'($random(seed))), '0);
        fill_en <= 1'b1;
        fill_way <= 2'(way);
        fill_set <= 6'(set_idx);
        fill_data <= line;
        shadow[way * NUM_SETS + set_idx] = line;
    endtask

    always @(negedge clk)
    begin
        if (!reset)
        begin
            check_value("result_valid", prev_valid, result_valid);
            check_value("suspend_thread", prev_suspend, suspend_thread);
            check_value("fault", prev_fault, fault);
            if (prev_valid)
            begin
                check_value("result_thread", prev_thread, result_thread);
                check_value("result_op", prev_op, result_op);
                check_value("result_is_io", prev_io, result_is_io);
                if (prev_fault)
                    check_value("fault_is_store", prev_store, fault_is_store);
                if (prev_read)
                    check_value("load_data", prev_line, load_data);
            end
            predict();
            check_value("store_en", request_valid && !exp_io && !request_is_load
                && !exp_unaligned && exp_mask != '0, store_en);
            check_value("cache_miss", request_valid && !exp_io && request_is_load
                && !exp_hit && !exp_unaligned, cache_miss);
            check_value("io_read_en", request_valid && exp_io && request_is_load, io_read_en);
            check_value("io_write_en", request_valid && exp_io && !request_is_load,
                io_write_en);
            if (request_valid && !exp_io && !request_is_load && !exp_unaligned)
            begin
                check_value("store_mask", exp_mask, store_mask);
                check_value("store_data", exp_data, store_data);
                check_value("store_line_addr", request_addr[31:6], store_line_addr);
                check_value("store_thread", request_thread, store_thread);
            end
            if (cache_miss)
            begin
                check_value("miss_line_addr", request_addr[31:6], miss_line_addr);
                check_value("miss_thread", request_thread, miss_thread);
            end
            if (request_valid && exp_io)
            begin
                check_value("io_addr", {16'd0, request_addr[15:0]}, io_addr);
                check_value("io_write_value", store_value[0], io_write_value);
                check_value("io_thread", request_thread, io_thread);
            end
            prev_valid = request_valid;
            prev_suspend = request_valid && !exp_io && request_is_load && !exp_hit
                && !exp_unaligned;
            prev_fault = request_valid && !exp_io && exp_unaligned;
            prev_read = request_valid && !exp_io && request_is_load && exp_hit;
            prev_store = !request_is_load;
            prev_io = exp_io;
            prev_thread = request_thread;
            prev_op = request_op;
            prev_line = shadow[exp_way * NUM_SETS + request_addr[11:6]];
        end
    end

    // Watchdog sized from the number of driven cycles
    initial
    begin
        #((NUM_TESTS + 20) * 8);
        $display("Watchdog: the run timed out before all tests completed");
        $display("SIMULATION FAILED");
        $fatal(1, "Timeout");
    end

    initial
    begin
        int k;
        mem_op_t op;
        seed = 66568;
        clk = 1'b0;
        reset = 1'b1;
        request_valid = 1'b0;
        request_op = MEM_B;
        request_is_load = 1'b0;
        request_thread = '0;
        request_addr = '0;
        store_value = '0;
        lane_mask = '0;
        way_valid = '0;
        way_tag = '0;
        fill_en = 1'b0;
        fill_way = '0;
        fill_set = '0;
        fill_data = '0;
        prev_valid = 1'b0;
        prev_suspend = 1'b0;
        prev_fault = 1'b0;
        for (int w = 0; w < NUM_WAYS; w++)
            for (int s = 0; s < NUM_SETS; s++)
                model_valid[w][s] = 1'b0;
        repeat (2) @(posedge clk);
        reset <= 1'b0;

        repeat (N_FILL)
            fill_line({$random(seed)} % NUM_WAYS, {$random(seed)} % NUM_SETS);
        repeat (N_HIT)
        begin
            k = {$random(seed)} % fill_way_q.size();
            op = mem_op_t'(2'($random(seed)));
            drive_request(op, 1'b1, make_addr(
                model_tag[fill_way_q[k]][fill_set_q[k]], 6'(fill_set_q[k]),
                op, 6'($random(seed))), '0);
        end
        repeat (N_COLLIDE)
        begin
            k = {$random(seed)} % fill_way_q.size();
            load_during_fill(fill_way_q[k], fill_set_q[k]);
        end
        // Tags with the top bit set never match a filled line
        repeat (N_MISS)
            drive_request(MEM_L, 1'b1, make_addr({4'b1000, 16'($random(seed))},
                6'($random(seed)), MEM_L, 6'($random(seed))), '0);
        repeat (N_SCALAR)
        begin
            k = {$random(seed)} % 3;
            drive_request(mem_op_t'(k), 1'b0, make_addr({1'b0, 19'($random(seed))},
                6'($random(seed)), mem_op_t'(k), 6'($random(seed))), '0);
        end
        repeat (N_BLOCK)
            drive_request(MEM_BLOCK, 1'b0, make_addr({1'b0, 19'($random(seed))},
                6'($random(seed)), MEM_BLOCK, 6'd0), 16'($random(seed)));
        drive_request(MEM_BLOCK, 1'b0, make_addr(20'h01234, 6'd5, MEM_BLOCK, 6'd0), '0);
        repeat (N_UNALIGNED)
            drive_request(mem_op_t'(1 + {$random(seed)} % 3), 1'($random(seed)),
                {1'b0, 25'($random(seed)), 6'($random(seed)) | 6'd1}, 16'hffff);
        repeat (N_IO)
            drive_request(mem_op_t'(2'($random(seed))), 1'($random(seed)),
                {16'hffff, 16'($random(seed))}, '0);

        @(posedge clk);
        request_valid <= 1'b0;
        repeat (3) @(posedge clk);
        $display("SIMULATION PASSED");
        $finish;
    end

endmodule

//--- tb.f
src/dcache_pkg.sv
src/mem_access_decode.sv
src/way_hit_check.sv
src/store_align.sv
src/line_data_ram.sv
src/stage_result.sv
src/dcache_data_stage.sv
dv/tb_dcache_data_stage.sv

//--- Bender.yml
package:
  name: dcache_data_stage

sources:
  - src/dcache_pkg.sv
  - src/mem_access_decode.sv
  - src/way_hit_check.sv
  - src/store_align.sv
  - src/line_data_ram.sv
  - src/stage_result.sv
  - src/dcache_data_stage.sv
  - target: test
    files:
      - dv/tb_dcache_data_stage.sv
